// ==== rtl/hamming.svh ====
/*
  Width helpers for Hamming single-error-correcting codes.
  Include this header in any module that sizes Hamming data, parity or block
  vectors from a parameter. Both macros fold to constants at elaboration.
*/

`ifndef HAMMING_SVH
`define HAMMING_SVH

// Smallest parity count p whose block of 2^p - 1 bits holds the data width
// Each step is the largest data width that p parity bits can protect
// p = 2 covers 1 bit
// p = 3 covers 4 bits
// p = 4 covers 11 bits
// p = 5 covers 26 bits
// p = 6 covers 57 bits
// p = 7 covers 120 bits
// p = 8 covers 247 bits
`define GET_HAMMING_PARITY_WIDTH(data_width) \
  (((data_width) <= 1)   ? 2 : \
   ((data_width) <= 4)   ? 3 : \
   ((data_width) <= 11)  ? 4 : \
   ((data_width) <= 26)  ? 5 : \
   ((data_width) <= 57)  ? 6 : \
   ((data_width) <= 120) ? 7 : \
   ((data_width) <= 247) ? 8 : 9)

// Largest data width protected by a given parity count
// Full block is 2^p - 1 positions and p of them carry parity
`define GET_HAMMING_DATA_WIDTH(parity_width) \
  ((1 << (parity_width)) - (parity_width) - 1)

// Block layout used across the project
// Position n (1-based) lives in block bit n-1
// Parity bit k sits at position 2^k, data fills the remaining positions in order
// A block narrower than the full 2^p - 1 is a prefix of the full block,
// so zero padding of the data only adds zero positions at the top end

`endif

// ==== rtl/hamming_pkg.sv ====
/*
  Position helpers shared by the Hamming encoder, corrector and memory.
  Positions are 1-based block indices, parity sits at the powers of two.
  Import with a wildcard in the module header of any user.
*/

`default_nettype none

package hamming_pkg;

  // Upper bound on loop iterations when walking parity positions
  localparam int HAMMING_MAX_PARITY = 16;

  // True for positions 1, 2, 4, 8 ...
  // Position 0 does not exist in the block
  function automatic bit hamming_is_parity_pos(input int pos);
    return (pos > 0) && ((pos & (pos - 1)) == 0);
  endfunction

  // Block position holding data bit i (i counts from 0)
  // Start one past the index and skip over every parity slot at or below it
  // Walking k upwards catches slots that the skipping itself moves past
  function automatic int hamming_data_pos(input int i);
    int pos;
    pos = i + 1;
    for (int k = 0; k < HAMMING_MAX_PARITY; k++) begin
      if ((1 << k) <= pos) begin
        pos++;
      end
    end
    return pos;
  endfunction

  // Quick sanity of the mapping
  //   data bit 0 -> position 3
  //   data bit 1 -> position 5
  //   data bit 3 -> position 7
  //   data bit 4 -> position 9

endpackage

`default_nettype wire

// ==== rtl/ecc_mem_pkg.sv ====
/*
  Command and response encodings of the ECC memory.
  Import with a wildcard wherever the command or status types are needed.
*/

`default_nettype none

package ecc_mem_pkg;

  // Command opcodes carried on cmd_op
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_FLIP  = 2'd2
  } ecc_op_e;

  // Read response status
  // Corrected means one bit was repaired before the data left the memory
  typedef enum logic {
    ST_CLEAN     = 1'b0,
    ST_CORRECTED = 1'b1
  } ecc_status_e;

  // Width of the saturating corrected-read counter
  localparam int ERR_COUNT_WIDTH = 16;

endpackage

`default_nettype wire

// ==== rtl/hamming_encoder.sv ====
/*
  Combinational Hamming encoder.
  Scatters data into the non-power-of-two positions of a block and fills
  each power-of-two position with the even parity of the positions it covers.
*/

`timescale 1ns/1ps
`default_nettype none

`include "hamming.svh"

module hamming_encoder
  import hamming_pkg::*;
#(
  parameter  int DATA_WIDTH   = 8,
  localparam int PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam int BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH
) (
  input  logic [DATA_WIDTH-1:0]  data,
  output logic [BLOCK_WIDTH-1:0] block
);

  // Data bits at their block positions, parity slots still zero
  logic [BLOCK_WIDTH-1:0] scattered;

  always_comb begin
    scattered = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      scattered[hamming_data_pos(i) - 1] = data[i];
    end
  end

  // Parity k covers every data position whose index has bit k set
  // Parity slots themselves are skipped so the order of fill does not matter
  always_comb begin
    logic parity;
    block = scattered;
    for (int k = 0; k < PARITY_WIDTH; k++) begin
      parity = 1'b0;
      for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
        if (!hamming_is_parity_pos(pos) && pos[k]) begin
          parity = parity ^ scattered[pos-1];
        end
      end
      // Slot 2^k always falls inside the block for a valid parity count
      block[(1 << k) - 1] = parity;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hamming_block_corrector.sv ====
/*
  Combinational single-error corrector for a packed Hamming block.
  The syndrome points at the flipped position, zero means no error seen.
  Works on any block width, parity and data bits already interleaved.
*/

`timescale 1ns/1ps
`default_nettype none

module hamming_block_corrector #(
  parameter  int BLOCK_WIDTH    = 15,
  localparam int SYNDROME_WIDTH = $clog2(BLOCK_WIDTH + 1)
) (
  input  logic [BLOCK_WIDTH-1:0] block,
  output logic                   error,
  output logic [BLOCK_WIDTH-1:0] corrected_block
);

  // XOR of the 1-based indices of every set position
  logic [SYNDROME_WIDTH-1:0] syndrome;

  always_comb begin
    syndrome = '0;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      if (block[pos-1]) begin
        syndrome = syndrome ^ SYNDROME_WIDTH'(pos);
      end
    end
  end

  // A syndrome past the last position can only come from multiple flips
  // in a shortened block, so leave such a block alone
  assign error = (syndrome != '0) && (int'(syndrome) <= BLOCK_WIDTH);

  // Invert the single addressed position
  always_comb begin
    corrected_block = block;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      if (error && (int'(syndrome) == pos)) begin
        corrected_block[pos-1] = ~block[pos-1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hamming_corrector.sv ====
/*
  Hamming corrector for separate data and parity vectors.
  Pads the data to the full width of its parity count, packs a block,
  corrects it and unpacks both corrected data and corrected parity.
  Returning the parity lets a caller rebuild and store the repaired block.
*/

`timescale 1ns/1ps
`default_nettype none

`include "hamming.svh"

module hamming_corrector
  import hamming_pkg::*;
#(
  parameter  int DATA_WIDTH   = 8,
  localparam int PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH)
) (
  input  logic [DATA_WIDTH-1:0]   data,
  input  logic [PARITY_WIDTH-1:0] code,
  output logic                    error,
  output logic [DATA_WIDTH-1:0]   corrected_data,
  output logic [PARITY_WIDTH-1:0] corrected_code
);

  // Full-length block for this parity count
  localparam int PADDED_DATA_WIDTH  = `GET_HAMMING_DATA_WIDTH(PARITY_WIDTH);
  localparam int PADDED_BLOCK_WIDTH = PADDED_DATA_WIDTH + PARITY_WIDTH;

  logic [PADDED_DATA_WIDTH-1:0]  data_padded;
  logic [PADDED_BLOCK_WIDTH-1:0] block_padded;
  logic [PADDED_BLOCK_WIDTH-1:0] corrected_block_padded;
  logic [PADDED_DATA_WIDTH-1:0]  corrected_data_padded;

  // Zero extension, the extra data bits land at the top positions
  assign data_padded = PADDED_DATA_WIDTH'(data);

  // Pack data and parity into block order
  always_comb begin
    block_padded = '0;
    for (int i = 0; i < PADDED_DATA_WIDTH; i++) begin
      block_padded[hamming_data_pos(i) - 1] = data_padded[i];
    end
    for (int k = 0; k < PARITY_WIDTH; k++) begin
      block_padded[(1 << k) - 1] = code[k];
    end
  end

  hamming_block_corrector #(
    .BLOCK_WIDTH ( PADDED_BLOCK_WIDTH )
  ) block_corrector (
    .block           ( block_padded           ),
    .error           ( error                  ),
    .corrected_block ( corrected_block_padded )
  );

  // Unpack the repaired block
  always_comb begin
    corrected_data_padded = '0;
    corrected_code        = '0;
    for (int i = 0; i < PADDED_DATA_WIDTH; i++) begin
      corrected_data_padded[i] = corrected_block_padded[hamming_data_pos(i) - 1];
    end
    for (int k = 0; k < PARITY_WIDTH; k++) begin
      corrected_code[k] = corrected_block_padded[(1 << k) - 1];
    end
  end

  // Drop the padding
  assign corrected_data = corrected_data_padded[DATA_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== rtl/ecc_memory.sv ====
/*
  ECC-protected memory with Hamming single-error correction and scrubbing.
  One single-cycle command per edge, no back-pressure. Reads answer with data
  and status one edge after acceptance, writes and flips give no response.
  A corrected read writes its repaired block back unless a command owns the port.
*/

`timescale 1ns/1ps
`default_nettype none

`include "hamming.svh"

module ecc_memory
  import ecc_mem_pkg::*, hamming_pkg::*;
#(
  parameter  int DATA_WIDTH     = 8,
  parameter  int DEPTH          = 16,
  localparam int PARITY_WIDTH   = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam int BLOCK_WIDTH    = DATA_WIDTH + PARITY_WIDTH,
  localparam int ADDR_WIDTH     = $clog2(DEPTH),
  localparam int FLIP_POS_WIDTH = $clog2(BLOCK_WIDTH + 1)
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  ecc_op_e                    cmd_op,
  input  logic [ADDR_WIDTH-1:0]      cmd_addr,
  input  logic [DATA_WIDTH-1:0]      cmd_wdata,
  input  logic [FLIP_POS_WIDTH-1:0]  cmd_flip_pos,
  output logic                       rsp_valid,
  output logic [DATA_WIDTH-1:0]      rsp_data,
  output ecc_status_e                rsp_status,
  output logic [ERR_COUNT_WIDTH-1:0] error_count
);

  // Stored Hamming blocks, no reset
  logic [BLOCK_WIDTH-1:0] mem [DEPTH];

  // Command decode
  logic is_read;
  logic is_write;
  logic is_flip;

  assign is_read  = cmd_valid && (cmd_op == OP_READ);
  assign is_write = cmd_valid && (cmd_op == OP_WRITE);
  assign is_flip  = cmd_valid && (cmd_op == OP_FLIP);

  // Write path
  logic [BLOCK_WIDTH-1:0] enc_block;

  hamming_encoder #(
    .DATA_WIDTH ( DATA_WIDTH )
  ) encoder (
    .data  ( cmd_wdata ),
    .block ( enc_block )
  );

  // Flip mask, out of range positions give an all-zero mask
  logic [BLOCK_WIDTH-1:0] flip_mask;

  always_comb begin
    for (int b = 0; b < BLOCK_WIDTH; b++) begin
      flip_mask[b] = (cmd_flip_pos == FLIP_POS_WIDTH'(b));
    end
  end

  // Stage 1 holds the raw block read at the accepting edge
  logic                   s1_valid;
  logic [ADDR_WIDTH-1:0]  s1_addr;
  logic [BLOCK_WIDTH-1:0] s1_block;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= is_read;
    end
  end

  // Sees the array before any update at the same edge
  always_ff @(posedge clk) begin
    if (is_read) begin
      s1_addr  <= cmd_addr;
      s1_block <= mem[cmd_addr];
    end
  end

  // Split the block into data and parity for the corrector
  logic [DATA_WIDTH-1:0]   s1_data;
  logic [PARITY_WIDTH-1:0] s1_code;

  always_comb begin
    for (int i = 0; i < DATA_WIDTH; i++) begin
      s1_data[i] = s1_block[hamming_data_pos(i) - 1];
    end
    for (int k = 0; k < PARITY_WIDTH; k++) begin
      s1_code[k] = s1_block[(1 << k) - 1];
    end
  end

  logic                    corr_error;
  logic [DATA_WIDTH-1:0]   corr_data;
  logic [PARITY_WIDTH-1:0] corr_code;

  hamming_corrector #(
    .DATA_WIDTH ( DATA_WIDTH )
  ) corrector (
    .data           ( s1_data    ),
    .code           ( s1_code    ),
    .error          ( corr_error ),
    .corrected_data ( corr_data  ),
    .corrected_code ( corr_code  )
  );

  // Rebuild the repaired block for write-back
  logic [BLOCK_WIDTH-1:0] scrub_block;

  always_comb begin
    for (int i = 0; i < DATA_WIDTH; i++) begin
      scrub_block[hamming_data_pos(i) - 1] = corr_data[i];
    end
    for (int k = 0; k < PARITY_WIDTH; k++) begin
      scrub_block[(1 << k) - 1] = corr_code[k];
    end
  end

  // Single array write port
  // Commands win, a colliding scrub is simply lost
  logic                   scrub_req;
  logic                   wr_en;
  logic [ADDR_WIDTH-1:0]  wr_addr;
  logic [BLOCK_WIDTH-1:0] wr_block;

  assign scrub_req = s1_valid && corr_error;

  always_comb begin
    wr_en    = 1'b0;
    wr_addr  = cmd_addr;
    wr_block = enc_block;
    if (is_write) begin
      wr_en = 1'b1;
    end else if (is_flip) begin
      wr_en    = 1'b1;
      wr_block = mem[cmd_addr] ^ flip_mask;
    end else if (scrub_req) begin
      wr_en    = 1'b1;
      wr_addr  = s1_addr;
      wr_block = scrub_block;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_block;
    end
  end

  // Stage 2 is the response register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      rsp_data   <= corr_data;
      rsp_status <= corr_error ? ST_CORRECTED : ST_CLEAN;
    end
  end

  // Corrected reads, saturating at all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_count <= '0;
    end else if (scrub_req && (error_count != '1)) begin
      error_count <= error_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/ecc_memory_checker.sv ====
/*
  Scoreboard for the ECC memory testbench.
  Watches the command and response ports and keeps its own model of the
  stored Hamming blocks, the read pipeline and scrub write-back. Every read
  response and the error counter are compared on each clock edge.
  Prints one result line each time the testbench closes a test.
*/

`timescale 1ns/1ps
`default_nettype none

module ecc_memory_checker
  import ecc_mem_pkg::*;
#(
  parameter  int DATA_WIDTH     = 8,
  parameter  int DEPTH          = 16,
  parameter  int PARITY_WIDTH   = 4,
  parameter  int FLIP_POS_WIDTH = 4,
  localparam int ADDR_WIDTH     = $clog2(DEPTH),
  localparam int BLOCK_WIDTH    = DATA_WIDTH + PARITY_WIDTH
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  ecc_op_e                    cmd_op,
  input  logic [ADDR_WIDTH-1:0]      cmd_addr,
  input  logic [DATA_WIDTH-1:0]      cmd_wdata,
  input  logic [FLIP_POS_WIDTH-1:0]  cmd_flip_pos,
  input  logic                       rsp_valid,
  input  logic [DATA_WIDTH-1:0]      rsp_data,
  input  ecc_status_e                rsp_status,
  input  logic [ERR_COUNT_WIDTH-1:0] error_count,
  input  logic                       test_done,
  input  int                         test_id,
  output int                         checks,
  output int                         errors
);

  // Parity lives at positions 1, 2, 4, 8 ...
  function automatic bit power_of_two(input int pos);
    return (pos & (pos - 1)) == 0;
  endfunction

  // Data fills the remaining positions, lowest data bit first
  function automatic logic [BLOCK_WIDTH-1:0] encode(input logic [DATA_WIDTH-1:0] d);
    logic [BLOCK_WIDTH-1:0] b;
    int                     n;
    b = '0;
    n = 0;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      if (!power_of_two(pos)) begin
        b[pos-1] = d[n];
        n++;
      end
    end
    // Even parity over every data position whose index has bit k set
    for (int k = 0; k < PARITY_WIDTH; k++) begin
      for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
        if (!power_of_two(pos) && (((pos >> k) & 1) == 1)) begin
          b[(1 << k) - 1] = b[(1 << k) - 1] ^ b[pos-1];
        end
      end
    end
    return b;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] data_of(input logic [BLOCK_WIDTH-1:0] b);
    logic [DATA_WIDTH-1:0] d;
    int                    n;
    d = '0;
    n = 0;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      if (!power_of_two(pos)) begin
        d[n] = b[pos-1];
        n++;
      end
    end
    return d;
  endfunction

  // XOR of the indices of all set positions, points at a single flipped bit
  function automatic int syndrome_of(input logic [BLOCK_WIDTH-1:0] b);
    int s;
    s = 0;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      if (b[pos-1] == 1'b1) begin
        s = s ^ pos;
      end
    end
    return s;
  endfunction

  // Model of the array and of the two pipeline stages
  logic [BLOCK_WIDTH-1:0]     model_mem [DEPTH];
  logic                       s1_valid;
  logic [ADDR_WIDTH-1:0]      s1_addr;
  logic [BLOCK_WIDTH-1:0]     s1_block;
  logic                       exp_valid;
  logic [ADDR_WIDTH-1:0]      exp_addr;
  logic [DATA_WIDTH-1:0]      exp_data;
  ecc_status_e                exp_status;
  logic [ERR_COUNT_WIDTH-1:0] exp_count;
  int                         base_checks;
  int                         base_errors;

  always @(posedge clk or negedge rst_n) begin : model_step
    int                     syn;
    logic [BLOCK_WIDTH-1:0] fixed;
    logic                   scrub;
    logic [ADDR_WIDTH-1:0]  scrub_addr;
    if (!rst_n) begin
      s1_valid    = 1'b0;
      exp_valid   = 1'b0;
      exp_count   = '0;
      checks      = 0;
      errors      = 0;
      base_checks = 0;
      base_errors = 0;
    end else begin
      // Response due at this edge
      if (exp_valid && !rsp_valid) begin
        $display("Missing read response at %0t for address %0d", $time, exp_addr);
        errors++;
      end else if (!exp_valid && rsp_valid) begin
        $display("Response at %0t with no read two cycles before", $time);
        errors++;
      end else if (exp_valid) begin
        checks++;
        if ((rsp_data !== exp_data) || (rsp_status !== exp_status)) begin
          $display("Error at %0t: address %0d gave data %h status %0d, expected %h status %0d",
                   $time, exp_addr, rsp_data, rsp_status, exp_data, exp_status);
          errors++;
        end
      end
      if (error_count !== exp_count) begin
        $display("Error at %0t: error_count is %0d, expected %0d", $time, error_count, exp_count);
        errors++;
      end
      // Stage 1 read turns into the next response and maybe a scrub
      exp_valid  = s1_valid;
      scrub      = 1'b0;
      scrub_addr = s1_addr;
      fixed      = s1_block;
      if (s1_valid) begin
        syn = syndrome_of(s1_block);
        if ((syn != 0) && (syn <= BLOCK_WIDTH)) begin
          fixed[syn-1] = ~fixed[syn-1];
        end
        exp_addr   = s1_addr;
        exp_data   = data_of(fixed);
        exp_status = (syn != 0) ? ST_CORRECTED : ST_CLEAN;
        if (syn != 0) begin
          scrub = 1'b1;
          if (exp_count != '1) begin
            exp_count = exp_count + ERR_COUNT_WIDTH'(1);
          end
        end
      end
      // A read samples the array as it stood before this edge
      s1_valid = cmd_valid && (cmd_op == OP_READ);
      if (s1_valid) begin
        s1_addr  = cmd_addr;
        s1_block = model_mem[cmd_addr];
      end
      // One array write per edge, commands take the port from a scrub
      if (cmd_valid && (cmd_op == OP_WRITE)) begin
        model_mem[cmd_addr] = encode(cmd_wdata);
      end else if (cmd_valid && (cmd_op == OP_FLIP)) begin
        if (int'(cmd_flip_pos) < BLOCK_WIDTH) begin
          model_mem[cmd_addr][cmd_flip_pos] = ~model_mem[cmd_addr][cmd_flip_pos];
        end
      end else if (scrub) begin
        model_mem[scrub_addr] = fixed;
      end
      // Close a test on request
      if (test_done) begin
        if (errors == base_errors) begin
          $display("Test %0d ok: %0d checks", test_id, checks - base_checks);
        end else begin
          $display("Test %0d FAILED: %0d checks, %0d errors", test_id,
                   checks - base_checks, errors - base_errors);
        end
        base_checks = checks;
        base_errors = errors;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/ecc_memory_tb.sv ====
/*
  Testbench for the ECC memory.
  Drives write, read and flip commands from a seeded LCG through five tests
  and leaves all comparing to the checker, which models the stored blocks.
  Build with all.f and run with this module as the top.
*/

`timescale 1ns/1ps
`default_nettype none

module ecc_memory_tb
  import ecc_mem_pkg::*;
();

  localparam int DATA_WIDTH     = 8;
  localparam int DEPTH          = 16;
  // Four parity bits protect up to eleven data bits
  localparam int PARITY_WIDTH   = 4;
  localparam int BLOCK_WIDTH    = DATA_WIDTH + PARITY_WIDTH;
  localparam int ADDR_WIDTH     = $clog2(DEPTH);
  localparam int FLIP_POS_WIDTH = $clog2(BLOCK_WIDTH + 1);
  // Cycles allowed for the reads in flight to answer
  localparam int DRAIN_LIMIT    = 20;

  logic                       clk;
  logic                       rst_n;
  logic                       cmd_valid;
  ecc_op_e                    cmd_op;
  logic [ADDR_WIDTH-1:0]      cmd_addr;
  logic [DATA_WIDTH-1:0]      cmd_wdata;
  logic [FLIP_POS_WIDTH-1:0]  cmd_flip_pos;
  logic                       rsp_valid;
  logic [DATA_WIDTH-1:0]      rsp_data;
  ecc_status_e                rsp_status;
  logic [ERR_COUNT_WIDTH-1:0] error_count;
  logic                       test_done;
  int                         test_id;
  int                         check_count;
  int                         check_errors;
  logic [31:0]                rng_state;
  int                         reads_issued;
  int                         rsp_seen;
  bit                         timed_out;
  // Words flipped since their last write, so no word gets a double error
  bit                         flipped [DEPTH];

  ecc_memory #(
    .DATA_WIDTH ( DATA_WIDTH ),
    .DEPTH      ( DEPTH      )
  ) dut0 (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .cmd_valid    ( cmd_valid    ),
    .cmd_op       ( cmd_op       ),
    .cmd_addr     ( cmd_addr     ),
    .cmd_wdata    ( cmd_wdata    ),
    .cmd_flip_pos ( cmd_flip_pos ),
    .rsp_valid    ( rsp_valid    ),
    .rsp_data     ( rsp_data     ),
    .rsp_status   ( rsp_status   ),
    .error_count  ( error_count  )
  );

  ecc_memory_checker #(
    .DATA_WIDTH     ( DATA_WIDTH     ),
    .DEPTH          ( DEPTH          ),
    .PARITY_WIDTH   ( PARITY_WIDTH   ),
    .FLIP_POS_WIDTH ( FLIP_POS_WIDTH )
  ) checker0 (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .cmd_valid    ( cmd_valid    ),
    .cmd_op       ( cmd_op       ),
    .cmd_addr     ( cmd_addr     ),
    .cmd_wdata    ( cmd_wdata    ),
    .cmd_flip_pos ( cmd_flip_pos ),
    .rsp_valid    ( rsp_valid    ),
    .rsp_data     ( rsp_data     ),
    .rsp_status   ( rsp_status   ),
    .error_count  ( error_count  ),
    .test_done    ( test_done    ),
    .test_id      ( test_id      ),
    .checks       ( check_count  ),
    .errors       ( check_errors )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Count responses on the edge, the drain loop reads the count at negedge
  always @(posedge clk) begin
    if (!rst_n) begin
      rsp_seen <= 0;
    end else if (rsp_valid) begin
      rsp_seen <= rsp_seen + 1;
    end
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Upper LCG bits are the better distributed ones
  function automatic logic [ADDR_WIDTH-1:0] rand_addr();
    logic [31:0] r;
    r = lcg_next();
    return r[31 -: ADDR_WIDTH];
  endfunction

  function automatic logic [DATA_WIDTH-1:0] rand_data();
    logic [31:0] r;
    r = lcg_next();
    return r[27 -: DATA_WIDTH];
  endfunction

  // Bit index inside the block
  function automatic logic [FLIP_POS_WIDTH-1:0] rand_pos();
    logic [31:0] r;
    r = lcg_next();
    return FLIP_POS_WIDTH'(int'(r[31:16]) % BLOCK_WIDTH);
  endfunction

  task automatic send(input ecc_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                      input logic [DATA_WIDTH-1:0] wdata,
                      input logic [FLIP_POS_WIDTH-1:0] pos);
    @(posedge clk);
    cmd_valid    <= 1'b1;
    cmd_op       <= op;
    cmd_addr     <= addr;
    cmd_wdata    <= wdata;
    cmd_flip_pos <= pos;
    if (op == OP_READ) begin
      reads_issued++;
    end
  endtask

  task automatic idle();
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] d);
    send(OP_WRITE, addr, d, '0);
    flipped[addr] = 1'b0;
  endtask

  task automatic read_word(input logic [ADDR_WIDTH-1:0] addr);
    send(OP_READ, addr, '0, '0);
  endtask

  task automatic flip_bit(input logic [ADDR_WIDTH-1:0] addr,
                          input logic [FLIP_POS_WIDTH-1:0] pos);
    send(OP_FLIP, addr, '0, pos);
    flipped[addr] = 1'b1;
  endtask

  // Wait until every issued read has answered
  task automatic drain();
    int waited;
    idle();
    waited = 0;
    while (!timed_out && (rsp_seen < reads_issued) && (waited < DRAIN_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    if (!timed_out && (rsp_seen < reads_issued)) begin
      $display("Timed out at %0t waiting for %0d read responses", $time,
               reads_issued - rsp_seen);
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input int id);
    drain();
    @(posedge clk);
    test_id   <= id;
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  // Fill every word, then write and read back at random addresses
  task automatic run_write_read();
    logic [ADDR_WIDTH-1:0] addr;
    for (int a = 0; a < DEPTH; a++) begin
      write_word(ADDR_WIDTH'(a), rand_data());
    end
    for (int i = 0; i < 24; i++) begin
      addr = rand_addr();
      write_word(addr, rand_data());
      read_word(addr);
    end
    for (int a = 0; a < DEPTH; a++) begin
      read_word(ADDR_WIDTH'(a));
    end
    end_test(1);
  endtask

  // One flip at each block position, then a read after the scrub
  task automatic run_single_flips();
    logic [ADDR_WIDTH-1:0] addr;
    for (int p = 0; p < BLOCK_WIDTH; p++) begin
      addr = rand_addr();
      write_word(addr, rand_data());
      flip_bit(addr, FLIP_POS_WIDTH'(p));
      read_word(addr);
      drain();
      read_word(addr);
    end
    end_test(2);
  endtask

  // Second read issued before the scrub lands is corrected again
  task automatic run_scrub_timing();
    logic [ADDR_WIDTH-1:0] addr;
    for (int i = 0; i < 6; i++) begin
      addr = rand_addr();
      write_word(addr, rand_data());
      flip_bit(addr, rand_pos());
      read_word(addr);
      read_word(addr);
      drain();
      read_word(addr);
      drain();
    end
    end_test(3);
  endtask

  task automatic run_collisions();
    logic [ADDR_WIDTH-1:0] a;
    logic [ADDR_WIDTH-1:0] b;
    logic [ADDR_WIDTH-1:0] c;
    for (int i = 0; i < 3; i++) begin
      a = rand_addr();
      b = a ^ ADDR_WIDTH'(1);
      c = a ^ ADDR_WIDTH'(2);
      write_word(a, rand_data());
      write_word(b, rand_data());
      write_word(c, rand_data());
      // Write on the scrub edge, so a stays corrupted
      flip_bit(a, rand_pos());
      read_word(a);
      write_word(b, rand_data());
      drain();
      read_word(a);
      drain();
      read_word(a);
      drain();
      // Flip of another word on the scrub edge
      flip_bit(a, rand_pos());
      read_word(a);
      flip_bit(c, rand_pos());
      drain();
      read_word(a);
      read_word(c);
      drain();
      // Positions past the block leave the word clean
      for (int p = BLOCK_WIDTH; p < (1 << FLIP_POS_WIDTH); p++) begin
        flip_bit(b, FLIP_POS_WIDTH'(p));
        read_word(b);
      end
      drain();
    end
    end_test(4);
  endtask

  task automatic run_random_mix();
    logic [31:0]           r;
    logic [ADDR_WIDTH-1:0] addr;
    for (int a = 0; a < DEPTH; a++) begin
      write_word(ADDR_WIDTH'(a), rand_data());
    end
    for (int i = 0; i < 400; i++) begin
      r    = lcg_next();
      addr = r[31 -: ADDR_WIDTH];
      case (r[18:16])
        3'd3, 3'd4: write_word(addr, rand_data());
        3'd5: begin
          if (flipped[addr]) begin
            read_word(addr);
          end else begin
            flip_bit(addr, r[11 -: FLIP_POS_WIDTH]);
          end
        end
        3'd6: idle();
        default: read_word(addr);
      endcase
    end
    end_test(5);
  endtask

  initial begin
    rng_state    = 32'h9b7f_27e9;
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd_op       = OP_READ;
    cmd_addr     = '0;
    cmd_wdata    = '0;
    cmd_flip_pos = '0;
    test_done    = 1'b0;
    test_id      = 0;
    reads_issued = 0;
    timed_out    = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    run_write_read();
    run_single_flips();
    run_scrub_timing();
    run_collisions();
    run_random_mix();
    // Let the checker print its last line first
    @(negedge clk);
    $display("Summary: 5 tests, %0d response checks, %0d errors", check_count, check_errors);
    if (timed_out || (check_errors != 0)) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+rtl
rtl/hamming_pkg.sv
rtl/ecc_mem_pkg.sv
rtl/hamming_encoder.sv
rtl/hamming_block_corrector.sv
rtl/hamming_corrector.sv
rtl/ecc_memory.sv
testbench/ecc_memory_checker.sv
testbench/ecc_memory_tb.sv

// ==== Makefile ====
# Verilator build and run of the ECC memory testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -f all.f --top-module ecc_memory_tb -o ecc_memory_sim
	./obj_dir/ecc_memory_sim | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
